//--- vec_macros.svh
// Sizes and encodings for the vector front end
// VLENB must stay VLEN/8 and the largest vl (VLEN/8 * 8) must fit in vlen_t
// CSR addresses and opcodes follow the RVV 1.0 and base ISA encodings
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Vector register and element sizes
`define VEC_VLEN   128
`define VEC_ELEN   32
`define VEC_VLENB  (`VEC_VLEN / 8)

// Unit queue depth and instruction tag width
`define VEC_QDEPTH 4
`define VEC_IDW    4

// Vector CSR addresses
`define VEC_CSR_VSTART 12'h008
`define VEC_CSR_VXSAT  12'h009
`define VEC_CSR_VXRM   12'h00A
`define VEC_CSR_VCSR   12'h00F
`define VEC_CSR_VL     12'hC20
`define VEC_CSR_VTYPE  12'hC21
`define VEC_CSR_VLENB  12'hC22

// Major opcodes
`define VEC_OPC_OPV     7'b1010111
`define VEC_OPC_SYSTEM  7'b1110011
`define VEC_OPC_LOADFP  7'b0000111
`define VEC_OPC_STOREFP 7'b0100111

`endif

//--- vec_pkg.sv
// Types shared by the front end RTL and its testbench
// Enum codes match the vtype CSR fields of RVV 1.0
`default_nettype none

`include "vec_macros.svh"

package vec_pkg;

  // Element count, holds vl up to 128
  typedef logic [7:0] vlen_t;

  typedef enum logic [2:0] {
    EW_8  = 3'b000,
    EW_16 = 3'b001,
    EW_32 = 3'b010,
    EW_64 = 3'b011
  } vsew_e;

  // Signed exponent code, fractional values are negative
  typedef enum logic [2:0] {
    LMUL_1   = 3'b000,
    LMUL_2   = 3'b001,
    LMUL_4   = 3'b010,
    LMUL_8   = 3'b011,
    LMUL_RES = 3'b100,
    LMUL_F8  = 3'b101,
    LMUL_F4  = 3'b110,
    LMUL_F2  = 3'b111
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    vsew_e  vsew;
    vlmul_e vlmul;
  } vtype_t;

  typedef enum logic [1:0] {
    CON = 2'd0,
    VFU = 2'd1,
    LSU = 2'd2
  } ex_unit_e;

  typedef enum logic [1:0] {
    VCFG,
    VCSR,
    VARITH,
    VMEM
  } op_e;

  ////////////////////
  // Host side
  ////////////////////

  typedef struct packed {
    logic [31:0]           instr;
    logic [31:0]           rs1;
    logic [31:0]           rs2;
    logic [`VEC_IDW-1:0]   id;
  } issue_req_t;

  typedef struct packed {
    logic                accept;
    logic                writeback;
    logic                loadstore;
    logic [`VEC_IDW-1:0] id;
  } issue_resp_t;

  typedef struct packed {
    logic [`VEC_IDW-1:0]  id;
    logic [4:0]           rd;
    logic [`VEC_ELEN-1:0] data;
    logic                 we;
  } result_t;

  ////////////////////
  // Internal requests
  ////////////////////

  typedef struct packed {
    op_e                 op;
    ex_unit_e            ex_unit;
    logic [4:0]          rd;
    logic [4:0]          vd;
    logic [31:0]         rs1;
    logic [11:0]         csr_addr;
    logic                use_rd;
    logic                reset_vstart;
    logic                write_vstart;
    vtype_t              vtype;
    vlen_t               vl;
    vlen_t               vstart;
    logic [`VEC_IDW-1:0] id;
  } vec_req_t;

  typedef struct packed {
    vec_req_t req;
    logic     illegal;
  } dec_rsp_t;

endpackage

`default_nettype wire

//--- vec_decoder.sv
// One instruction per offer, result registered for one cycle
// Only vsetvli, OPIVV arithmetic, unit loads/stores and vector csrr/csrw decode
// The keep-vl form of vsetvli (rd and rs1 both x0) is flagged illegal
`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_decoder
  import vec_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       issue_valid_i,
  input  wire logic       issue_ready_i,
  input  wire issue_req_t issue_req_i,
  output logic            dec_valid_o,
  output dec_rsp_t        dec_rsp_o
);

  logic [31:0] instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rd_idx;
  logic [4:0]  rs1_idx;
  logic [11:0] csr;
  logic        take;
  logic        csr_known;
  dec_rsp_t    rsp_d;
  dec_rsp_t    rsp_q;
  logic        valid_q;

  assign instr   = issue_req_i.instr;
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign rd_idx  = instr[11:7];
  assign rs1_idx = instr[19:15];
  assign csr     = instr[31:20];
  assign take    = issue_valid_i & issue_ready_i;

  // Vector CSRs, fixed-point ones included
  assign csr_known = (csr == `VEC_CSR_VSTART) || (csr == `VEC_CSR_VXSAT) ||
                     (csr == `VEC_CSR_VXRM)   || (csr == `VEC_CSR_VCSR)  ||
                     (csr == `VEC_CSR_VL)     || (csr == `VEC_CSR_VTYPE) ||
                     (csr == `VEC_CSR_VLENB);

  always_comb begin : proc_decode
    rsp_d              = '0;
    rsp_d.illegal      = 1'b1;
    rsp_d.req.rd       = rd_idx;
    rsp_d.req.vd       = rd_idx;
    rsp_d.req.rs1      = issue_req_i.rs1;
    rsp_d.req.csr_addr = csr;
    rsp_d.req.id       = issue_req_i.id;

    case (opcode)
      `VEC_OPC_OPV: begin
        if (funct3 == 3'b111 && !instr[31] && (rs1_idx != '0 || rd_idx != '0)) begin
          // vsetvli, vtype comes from zimm
          rsp_d.req.op          = VCFG;
          rsp_d.req.ex_unit     = CON;
          rsp_d.req.use_rd      = (rd_idx != '0);
          rsp_d.req.vtype.vsew  = vsew_e'(instr[25:23]);
          rsp_d.req.vtype.vlmul = vlmul_e'(instr[22:20]);
          rsp_d.illegal         = 1'b0;
        end else if (funct3 == 3'b000) begin
          rsp_d.req.op           = VARITH;
          rsp_d.req.ex_unit      = VFU;
          rsp_d.req.reset_vstart = 1'b1;
          rsp_d.illegal          = 1'b0;
        end
      end
      `VEC_OPC_SYSTEM: begin
        rsp_d.req.op      = VCSR;
        rsp_d.req.ex_unit = CON;
        if (funct3 == 3'b010 && rs1_idx == '0 && csr_known) begin
          // csrr
          rsp_d.req.use_rd = (rd_idx != '0);
          rsp_d.illegal    = 1'b0;
        end else if (funct3 == 3'b001 && rd_idx == '0 && csr == `VEC_CSR_VSTART) begin
          // csrw, only vstart is writable
          rsp_d.req.write_vstart = 1'b1;
          rsp_d.illegal          = 1'b0;
        end
      end
      `VEC_OPC_LOADFP, `VEC_OPC_STOREFP: begin
        rsp_d.req.op           = VMEM;
        rsp_d.req.ex_unit      = LSU;
        rsp_d.req.reset_vstart = 1'b1;
        rsp_d.illegal          = 1'b0;
        case (funct3)
          3'b000:  rsp_d.req.vtype.vsew = EW_8;
          3'b101:  rsp_d.req.vtype.vsew = EW_16;
          3'b110:  rsp_d.req.vtype.vsew = EW_32;
          default: rsp_d.illegal = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_valid
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;
    end
  end

  always_ff @(posedge clk_i) begin : proc_rsp
    if (take) begin
      rsp_q <= rsp_d;
    end
  end

  assign dec_valid_o = valid_q;
  assign dec_rsp_o   = rsp_q;

  // Controller holds ready low in the strobe cycle, so no back-to-back offers
  assert property (@(posedge clk_i) disable iff (!rst_ni) dec_valid_o |=> !dec_valid_o)
    else $error("decoder strobe high for two cycles");

endmodule

`default_nettype wire

//--- vec_controller.sv
// Takes one decoded request every other cycle at most
// A request whose queue is full waits in a single stall buffer, ready stays low
// Unit requests are stamped with vl, vtype and vstart at the time they issue
`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_controller
  import vec_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     dec_valid_i,
  input  wire dec_rsp_t dec_rsp_i,
  output logic          issue_ready_o,
  output logic          issue_resp_valid_o,
  output issue_resp_t   issue_resp_o,
  output logic          result_valid_o,
  output result_t       result_o,
  output logic          vfu_push_o,
  output logic          lsu_push_o,
  output vec_req_t      unit_req_o,
  input  wire logic     vfu_full_i,
  input  wire logic     lsu_full_i
);

  localparam vtype_t VTYPE_VILL = '{vill: 1'b1, vsew: EW_8, vlmul: LMUL_1};

  ////////////////////
  // State
  ////////////////////

  vlen_t    vl_q, vl_d;
  vlen_t    vstart_q, vstart_d;
  vtype_t   vtype_q, vtype_d;
  logic     ready_q, ready_d;
  logic     buf_valid_q, buf_valid_d;
  vec_req_t buf_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      vl_q        <= '0;
      vstart_q    <= '0;
      vtype_q     <= VTYPE_VILL;
      ready_q     <= 1'b1;
      buf_valid_q <= 1'b0;
    end else begin
      vl_q        <= vl_d;
      vstart_q    <= vstart_d;
      vtype_q     <= vtype_d;
      ready_q     <= ready_d;
      buf_valid_q <= buf_valid_d;
    end
  end

  ////////////////////
  // Issue decision
  ////////////////////

  vec_req_t cur;
  logic     is_unit;
  logic     tgt_full;
  logic     new_ok;
  logic     stall_new;
  logic     release_buf;
  logic     issue;

  // Buffer and strobe never coincide, see assertion below
  assign cur       = buf_valid_q ? buf_q : dec_rsp_i.req;
  assign is_unit   = (cur.ex_unit != CON);
  assign tgt_full  = ((cur.ex_unit == VFU) && vfu_full_i) || ((cur.ex_unit == LSU) && lsu_full_i);
  assign new_ok    = dec_valid_i && !dec_rsp_i.illegal && !(is_unit && vtype_q.vill);
  assign stall_new = new_ok && is_unit && tgt_full;
  assign release_buf = buf_valid_q && !tgt_full;
  assign issue     = (new_ok && !stall_new) || release_buf;

  always_ff @(posedge clk_i) begin : proc_buf
    if (stall_new) begin
      buf_q <= dec_rsp_i.req;
    end
  end

  always_comb begin : proc_ready
    buf_valid_d = buf_valid_q;
    ready_d     = ready_q;
    if (stall_new) begin
      buf_valid_d = 1'b1;
      ready_d     = 1'b0;
    end else if (release_buf) begin
      buf_valid_d = 1'b0;
      ready_d     = 1'b1;
    end
  end

  // No new offer while a decoded one is being answered
  assign issue_ready_o = ready_q & ~dec_valid_i;

  assign issue_resp_valid_o     = (dec_valid_i && !stall_new) || release_buf;
  assign issue_resp_o.accept    = issue;
  assign issue_resp_o.writeback = issue && ((cur.op == VCFG) || (cur.op == VCSR && cur.use_rd));
  assign issue_resp_o.loadstore = issue && (cur.op == VMEM);
  assign issue_resp_o.id        = cur.id;

  ////////////////////
  // vsetvli
  ////////////////////

  logic [2:0]        lmul_bits;
  logic signed [3:0] lmul_exp;
  logic signed [3:0] sew_code;
  logic              cfg_illegal;
  logic [31:0]       vlmax;
  logic [31:0]       cfg_vl;

  assign lmul_bits = cur.vtype.vlmul;
  assign lmul_exp  = {lmul_bits[2], lmul_bits};
  assign sew_code  = {1'b0, cur.vtype.vsew};

  // SEW may not exceed ELEN * LMUL
  assign cfg_illegal = (cur.vtype.vsew > EW_32) || (cur.vtype.vlmul == LMUL_RES) ||
                       (cur.vtype.vlmul == LMUL_F8) || ((lmul_exp + 4'sd2) < sew_code);

  always_comb begin : proc_vlmax
    vlmax = 32'(`VEC_VLENB) >> cur.vtype.vsew;
    case (cur.vtype.vlmul)
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      default: ;
    endcase
  end

  assign cfg_vl = cfg_illegal ? '0 :
                  (cur.rs1 == '1) ? vlmax :
                  (cur.rs1 < vlmax) ? cur.rs1 : vlmax;

  always_comb begin : proc_csr
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    vstart_d = vstart_q;
    if (issue) begin
      if (cur.op == VCFG) begin
        vtype_d = cfg_illegal ? VTYPE_VILL : cur.vtype;
        vl_d    = vlen_t'(cfg_vl);
      end
      if (cur.write_vstart) begin
        vstart_d = vlen_t'(cur.rs1);
      end
      if (cur.reset_vstart) begin
        vstart_d = '0;
      end
    end
  end

  ////////////////////
  // Results and units
  ////////////////////

  always_comb begin : proc_result
    result_valid_o = issue && !is_unit;
    result_o.id    = cur.id;
    result_o.rd    = cur.rd;
    result_o.we    = (cur.op == VCFG) || cur.use_rd;
    result_o.data  = '0;
    if (cur.op == VCFG) begin
      result_o.data = cfg_vl;
    end else if (cur.use_rd) begin
      // Fixed-point CSRs read as zero
      case (cur.csr_addr)
        `VEC_CSR_VSTART: result_o.data = 32'(vstart_q);
        `VEC_CSR_VL:     result_o.data = 32'(vl_q);
        `VEC_CSR_VTYPE:  result_o.data = {vtype_q.vill, 25'b0, vtype_q.vsew, vtype_q.vlmul};
        `VEC_CSR_VLENB:  result_o.data = 32'(`VEC_VLENB);
        default:         result_o.data = '0;
      endcase
    end
  end

  always_comb begin : proc_unit_req
    unit_req_o        = cur;
    unit_req_o.vl     = vl_q;
    unit_req_o.vtype  = vtype_q;
    unit_req_o.vstart = vstart_q;
  end

  assign vfu_push_o = issue && (cur.ex_unit == VFU);
  assign lsu_push_o = issue && (cur.ex_unit == LSU);

  // Relies on the decoder seeing ready low while the buffer is held
  assert property (@(posedge clk_i) disable iff (!rst_ni) buf_valid_q |-> !dec_valid_i)
    else $error("stall buffer overwritten");

endmodule

`default_nettype wire

//--- vec_unit_queue.sv
// In-order FIFO of VEC_QDEPTH entries for one execution unit
// Push while full is not allowed, the writer must watch full_o
// Head is visible one cycle after the push that fills an empty queue
`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_unit_queue
  import vec_pkg::*;
#(
  parameter type payload_t = vec_req_t
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  output logic          full_o,
  output logic          valid_o,
  output payload_t      data_o,
  input  wire logic     ready_i
);

  localparam int unsigned DEPTH = `VEC_QDEPTH;
  localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  payload_t        mem_q [DEPTH];
  logic [PW-1:0]   wr_ptr_q;
  logic [PW-1:0]   rd_ptr_q;
  logic [CW-1:0]   count_q;
  logic            pop;

  assign full_o  = (count_q == CW'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin : proc_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i)
    else $error("push into full queue");

endmodule

`default_nettype wire

//--- vec_frontend_top.sv
// Vector front end: decoder, controller and one queue per execution unit
// Offers are taken at most every other cycle, results need no ready
`timescale 1ns/1ps
`default_nettype none

module vec_frontend_top
  import vec_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Issue port
  input  wire logic       issue_valid_i,
  output logic            issue_ready_o,
  input  wire issue_req_t issue_req_i,
  output logic            issue_resp_valid_o,
  output issue_resp_t     issue_resp_o,
  // Results
  output logic            result_valid_o,
  output result_t         result_o,
  // Unit requests
  output logic            vfu_req_valid_o,
  output vec_req_t        vfu_req_o,
  input  wire logic       vfu_req_ready_i,
  output logic            lsu_req_valid_o,
  output vec_req_t        lsu_req_o,
  input  wire logic       lsu_req_ready_i
);

  logic     dec_valid;
  dec_rsp_t dec_rsp;
  logic     vfu_push;
  logic     lsu_push;
  logic     vfu_full;
  logic     lsu_full;
  vec_req_t unit_req;

  vec_decoder u_dec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_i),
    .issue_ready_i (issue_ready_o),
    .issue_req_i   (issue_req_i),
    .dec_valid_o   (dec_valid),
    .dec_rsp_o     (dec_rsp)
  );

  vec_controller u_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .dec_valid_i        (dec_valid),
    .dec_rsp_i          (dec_rsp),
    .issue_ready_o      (issue_ready_o),
    .issue_resp_valid_o (issue_resp_valid_o),
    .issue_resp_o       (issue_resp_o),
    .result_valid_o     (result_valid_o),
    .result_o           (result_o),
    .vfu_push_o         (vfu_push),
    .lsu_push_o         (lsu_push),
    .unit_req_o         (unit_req),
    .vfu_full_i         (vfu_full),
    .lsu_full_i         (lsu_full)
  );

  vec_unit_queue #(.payload_t(vec_req_t)) u_vfu_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (vfu_push),
    .data_i  (unit_req),
    .full_o  (vfu_full),
    .valid_o (vfu_req_valid_o),
    .data_o  (vfu_req_o),
    .ready_i (vfu_req_ready_i)
  );

  vec_unit_queue #(.payload_t(vec_req_t)) u_lsu_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (lsu_push),
    .data_i  (unit_req),
    .full_o  (lsu_full),
    .valid_o (lsu_req_valid_o),
    .data_o  (lsu_req_o),
    .ready_i (lsu_req_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_vec_frontend.sv
// Self-checking testbench for the vector front end
// Inputs change on rising edges, outputs are sampled on falling edges
// Expected vl, vtype and CSR values are worked out by hand from the vtype rules
`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module tb_vec_frontend
  import vec_pkg::*;
();

  localparam int unsigned TIMEOUT = 500;

  // One table row, unit CON means a result or nothing
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic        accept;
    logic [31:0] data;
    ex_unit_e    unit;
    vlen_t       vl;
    vtype_t      vtype;
    vlen_t       vstart;
  } step_t;

  logic        clk_i;
  logic        rst_ni;
  logic        issue_valid_i;
  logic        issue_ready_o;
  issue_req_t  issue_req_i;
  logic        issue_resp_valid_o;
  issue_resp_t issue_resp_o;
  logic        result_valid_o;
  result_t     result_o;
  logic        vfu_req_valid_o;
  vec_req_t    vfu_req_o;
  logic        vfu_req_ready_i;
  logic        lsu_req_valid_o;
  vec_req_t    lsu_req_o;
  logic        lsu_req_ready_i;
  logic        vfu_hold;

  step_t    steps[$];
  vec_req_t vfu_exp[$];
  vec_req_t lsu_exp[$];
  int       burst_at;

  vec_frontend_top dut0 (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .issue_valid_i      (issue_valid_i),
    .issue_ready_o      (issue_ready_o),
    .issue_req_i        (issue_req_i),
    .issue_resp_valid_o (issue_resp_valid_o),
    .issue_resp_o       (issue_resp_o),
    .result_valid_o     (result_valid_o),
    .result_o           (result_o),
    .vfu_req_valid_o    (vfu_req_valid_o),
    .vfu_req_o          (vfu_req_o),
    .vfu_req_ready_i    (vfu_req_ready_i),
    .lsu_req_valid_o    (lsu_req_valid_o),
    .lsu_req_o          (lsu_req_o),
    .lsu_req_ready_i    (lsu_req_ready_i)
  );

  always #2 clk_i = ~clk_i;

  // Random unit ready, VFU can be held off for the burst
  always @(posedge clk_i) begin : drive_ready
    vfu_req_ready_i <= !vfu_hold && ($urandom_range(3, 0) != 0);
    lsu_req_ready_i <= ($urandom_range(1, 0) != 0);
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_resp(input issue_resp_t got, input issue_resp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at time %0t: issue response %h, expected %h",
                          $time, got, exp));
    end
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at time %0t: result %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_unit_req(input vec_req_t got, input vec_req_t exp);
    if (got.op !== exp.op || got.ex_unit !== exp.ex_unit || got.vd !== exp.vd ||
        got.vtype !== exp.vtype || got.vl !== exp.vl || got.vstart !== exp.vstart ||
        got.id !== exp.id) begin
      abort_run($sformatf("Error at time %0t: unit request %h, expected %h",
                          $time, got, exp));
    end
  endtask

  // A pop happens at the next rising edge when both are high here
  always @(negedge clk_i) begin : watch_units
    if (rst_ni && vfu_req_valid_o && vfu_req_ready_i) begin
      if (vfu_exp.size() == 0) begin
        abort_run($sformatf("Error at time %0t: unexpected VFU request", $time));
      end
      check_unit_req(vfu_req_o, vfu_exp.pop_front());
    end
    if (rst_ni && lsu_req_valid_o && lsu_req_ready_i) begin
      if (lsu_exp.size() == 0) begin
        abort_run($sformatf("Error at time %0t: unexpected LSU request", $time));
      end
      check_unit_req(lsu_req_o, lsu_exp.pop_front());
    end
  end

  ////////////////////
  // Encodings
  ////////////////////

  // rd x5, rs1 x6, vta and vma clear
  function automatic logic [31:0] vsetvli_instr(input vsew_e sew, input vlmul_e lmul);
    return {6'b0, sew, lmul, 5'd6, 3'b111, 5'd5, `VEC_OPC_OPV};
  endfunction

  function automatic logic [31:0] csrr_instr(input logic [11:0] csr);
    return {csr, 5'd0, 3'b010, 5'd10, `VEC_OPC_SYSTEM};
  endfunction

  function automatic logic [31:0] csrw_instr(input logic [11:0] csr);
    return {csr, 5'd7, 3'b001, 5'd0, `VEC_OPC_SYSTEM};
  endfunction

  // vadd.vv vd, v2, v3, unmasked
  function automatic logic [31:0] vadd_instr(input logic [4:0] vd);
    return {6'b0, 1'b1, 5'd2, 5'd3, 3'b000, vd, `VEC_OPC_OPV};
  endfunction

  // Unit-stride load or store, base in x1
  function automatic logic [31:0] vmem_instr(input logic store, input logic [2:0] width,
                                             input logic [4:0] vd);
    return {7'b0000001, 5'd0, 5'd1, width, vd,
            store ? `VEC_OPC_STOREFP : `VEC_OPC_LOADFP};
  endfunction

  function automatic vtype_t legal_vtype(input vsew_e sew, input vlmul_e lmul);
    vtype_t v;
    v.vill  = 1'b0;
    v.vsew  = sew;
    v.vlmul = lmul;
    return v;
  endfunction

  // vtype CSR layout, vill in bit 31
  function automatic logic [31:0] vtype_word(input vtype_t v);
    return {v.vill, 25'b0, v.vsew, v.vlmul};
  endfunction

  ////////////////////
  // Table
  ////////////////////

  task automatic result_row(input logic [31:0] instr, input logic [31:0] rs1,
                            input logic [31:0] data);
    step_t s;
    s        = '0;
    s.instr  = instr;
    s.rs1    = rs1;
    s.accept = 1'b1;
    s.data   = data;
    steps.push_back(s);
  endtask

  task automatic unit_row(input logic [31:0] instr, input ex_unit_e unit, input vlen_t vl,
                          input vtype_t vtype, input vlen_t vstart);
    step_t s;
    s        = '0;
    s.instr  = instr;
    s.accept = 1'b1;
    s.unit   = unit;
    s.vl     = vl;
    s.vtype  = vtype;
    s.vstart = vstart;
    steps.push_back(s);
  endtask

  task automatic reject_row(input logic [31:0] instr);
    step_t s;
    s       = '0;
    s.instr = instr;
    steps.push_back(s);
  endtask

  task automatic build_table();
    vtype_t vt_a;
    vtype_t vt_b;
    vt_a = legal_vtype(EW_16, LMUL_1);
    vt_b = legal_vtype(EW_32, LMUL_8);
    // Reset state has vill set and vl zero
    result_row(csrr_instr(`VEC_CSR_VTYPE), '0, 32'h8000_0000);
    result_row(csrr_instr(`VEC_CSR_VL), '0, 32'd0);
    reject_row(vadd_instr(5'd1));
    // vlmax is 16 >> sew, scaled by LMUL
    result_row(vsetvli_instr(EW_32, LMUL_1), 32'd3, 32'd3);
    result_row(csrr_instr(`VEC_CSR_VL), '0, 32'd3);
    result_row(csrr_instr(`VEC_CSR_VTYPE), '0, vtype_word(legal_vtype(EW_32, LMUL_1)));
    result_row(vsetvli_instr(EW_8, LMUL_8), '1, 32'd128);
    result_row(vsetvli_instr(EW_16, LMUL_2), 32'd100, 32'd16);
    result_row(vsetvli_instr(EW_8, LMUL_F2), 32'd5, 32'd5);
    result_row(vsetvli_instr(EW_16, LMUL_F2), '1, 32'd4);
    result_row(vsetvli_instr(EW_8, LMUL_F4), 32'd7, 32'd4);
    result_row(vsetvli_instr(EW_32, LMUL_4), 32'd20, 32'd16);
    // Illegal pairs
    result_row(vsetvli_instr(EW_16, LMUL_F4), 32'd3, 32'd0);
    result_row(csrr_instr(`VEC_CSR_VTYPE), '0, 32'h8000_0000);
    result_row(csrr_instr(`VEC_CSR_VL), '0, 32'd0);
    reject_row(vadd_instr(5'd1));
    result_row(vsetvli_instr(EW_64, LMUL_1), 32'd2, 32'd0);
    result_row(vsetvli_instr(EW_8, LMUL_RES), 32'd2, 32'd0);
    result_row(vsetvli_instr(EW_8, LMUL_F8), 32'd2, 32'd0);
    result_row(vsetvli_instr(EW_32, LMUL_F2), 32'd2, 32'd0);
    reject_row(vmem_instr(1'b0, 3'b110, 5'd1));
    // vstart write, read back, cleared by a vector op
    result_row(vsetvli_instr(EW_16, LMUL_1), 32'd6, 32'd6);
    result_row(csrw_instr(`VEC_CSR_VSTART), 32'd3, 32'd0);
    result_row(csrr_instr(`VEC_CSR_VSTART), '0, 32'd3);
    unit_row(vadd_instr(5'd2), VFU, 8'd6, vt_a, 8'd3);
    result_row(csrr_instr(`VEC_CSR_VSTART), '0, 32'd0);
    result_row(csrr_instr(`VEC_CSR_VLENB), '0, 32'd16);
    result_row(csrr_instr(`VEC_CSR_VXRM), '0, 32'd0);
    // Mixed VFU and LSU traffic
    unit_row(vmem_instr(1'b0, 3'b110, 5'd3), LSU, 8'd6, vt_a, 8'd0);
    result_row(csrw_instr(`VEC_CSR_VSTART), 32'd2, 32'd0);
    unit_row(vmem_instr(1'b1, 3'b000, 5'd4), LSU, 8'd6, vt_a, 8'd2);
    unit_row(vadd_instr(5'd5), VFU, 8'd6, vt_a, 8'd0);
    result_row(vsetvli_instr(EW_32, LMUL_8), 32'd50, 32'd32);
    unit_row(vmem_instr(1'b0, 3'b101, 5'd6), LSU, 8'd32, vt_b, 8'd0);
    unit_row(vadd_instr(5'd7), VFU, 8'd32, vt_b, 8'd0);
    // Unknown encodings
    reject_row(32'h0000_0013);
    reject_row(csrr_instr(12'h300));
    reject_row(vmem_instr(1'b0, 3'b111, 5'd1));
    reject_row(vadd_instr(5'd1) | 32'h0000_1000);
    // Burst into a VFU queue that is held off
    burst_at = steps.size();
    for (int k = 0; k < 6; k++) begin
      unit_row(vadd_instr(5'(8 + k)), VFU, 8'd32, vt_b, 8'd0);
    end
  endtask

  ////////////////////
  // Issue port
  ////////////////////

  task automatic offer(input issue_req_t req);
    int unsigned n;
    n = 0;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_req_i   <= req;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      if (n == TIMEOUT) begin
        abort_run("Timeout: the issue port never became ready");
      end
      n++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
  endtask

  task automatic await_resp(output issue_resp_t resp, output logic res_valid,
                            output result_t res, output int unsigned waited);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!issue_resp_valid_o) begin
      if (n == TIMEOUT) begin
        abort_run("Timeout: no issue response arrived");
      end
      n++;
      @(negedge clk_i);
    end
    resp      = issue_resp_o;
    res_valid = result_valid_o;
    res       = result_o;
    waited    = n;
  endtask

  task automatic start_step(input step_t s, input int idx);
    issue_req_t req;
    vec_req_t   exp;
    req.instr = s.instr;
    req.rs1   = s.rs1;
    req.rs2   = '0;
    req.id    = `VEC_IDW'(idx);
    if (s.accept && s.unit != CON) begin
      exp         = '0;
      exp.op      = (s.unit == VFU) ? VARITH : VMEM;
      exp.ex_unit = s.unit;
      exp.vd      = s.instr[11:7];
      exp.vtype   = s.vtype;
      exp.vl      = s.vl;
      exp.vstart  = s.vstart;
      exp.id      = req.id;
      if (s.unit == VFU) begin
        vfu_exp.push_back(exp);
      end else begin
        lsu_exp.push_back(exp);
      end
    end
    offer(req);
  endtask

  task automatic finish_step(input step_t s, input int idx);
    issue_resp_t resp;
    issue_resp_t exp_resp;
    result_t     res;
    result_t     exp_res;
    logic        res_valid;
    logic        wb;
    int unsigned waited;
    await_resp(resp, res_valid, res, waited);
    // Target queue has room up to the fifth burst op, answer due in the strobe cycle
    if (idx < burst_at + 4 && waited != 0) begin
      abort_run($sformatf("Error at time %0t: response for step %0d came %0d cycles late",
                          $time, idx, waited));
    end
    // Every vsetvli in the table writes x5, csrw writes x0
    wb                 = s.accept && (s.unit == CON) && (s.instr[11:7] != 5'd0);
    exp_resp.accept    = s.accept;
    exp_resp.writeback = wb;
    exp_resp.loadstore = s.accept && (s.unit == LSU);
    exp_resp.id        = `VEC_IDW'(idx);
    check_resp(resp, exp_resp);
    if (s.accept && s.unit == CON) begin
      if (!res_valid) begin
        abort_run($sformatf("Error at time %0t: missing result for step %0d", $time, idx));
      end
      exp_res.id   = `VEC_IDW'(idx);
      exp_res.rd   = s.instr[11:7];
      exp_res.data = s.data;
      exp_res.we   = wb;
      check_result(res, exp_res);
    end else if (res_valid) begin
      abort_run($sformatf("Error at time %0t: unexpected result for step %0d", $time, idx));
    end
  endtask

  task automatic expect_stall();
    repeat (10) begin
      @(negedge clk_i);
      if (issue_resp_valid_o || issue_ready_o) begin
        abort_run($sformatf("Error at time %0t: issue port not stalled by a full VFU queue",
                            $time));
      end
    end
  endtask

  task automatic drain_units();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (vfu_exp.size() != 0 || lsu_exp.size() != 0 ||
           vfu_req_valid_o || lsu_req_valid_o) begin
      if (n == TIMEOUT) begin
        abort_run("Timeout: unit requests were not drained");
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  initial begin : run_test
    void'($urandom(32'h100e));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    issue_valid_i   = 1'b0;
    issue_req_i     = '0;
    vfu_req_ready_i = 1'b0;
    lsu_req_ready_i = 1'b0;
    vfu_hold        = 1'b0;
    build_table();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (issue_resp_valid_o || result_valid_o || vfu_req_valid_o || lsu_req_valid_o ||
        !issue_ready_o) begin
      abort_run($sformatf("Error at time %0t: outputs not idle after reset", $time));
    end
    for (int i = 0; i < steps.size(); i++) begin
      if (i == burst_at) begin
        drain_units();
        vfu_hold = 1'b1;
        repeat (2) @(posedge clk_i);
      end
      start_step(steps[i], i);
      // Fifth op of the burst finds the queue full
      if (i == burst_at + 4) begin
        expect_stall();
        vfu_hold = 1'b0;
      end
      finish_step(steps[i], i);
    end
    drain_units();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
vec_pkg.sv
vec_decoder.sv
vec_controller.sv
vec_unit_queue.sv
vec_frontend_top.sv
tb_vec_frontend.sv

//--- Makefile
# Verilator build and run of the vector front end testbench

TOP := tb_vec_frontend
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Pass or fail is read from the log
run: build
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module vec_frontend_top

clean:
	rm -rf obj_dir $(LOG)
